//--- fp2_nr_top.f
hw/fp2_nr_pkg.sv
hw/fe_add_mod.sv
hw/fe_sub_mod.sv
hw/fe2_mul_by_nonresidue_s.sv
hw/fp2_nr_top.sv
tests/tb_fp2_nr_top.sv

//--- Bender.yml
package:
  name: fp2_nr

sources:
  # RTL in compile order
  - hw/fp2_nr_pkg.sv
  - hw/fe_add_mod.sv
  - hw/fe_sub_mod.sv
  - hw/fe2_mul_by_nonresidue_s.sv
  - hw/fp2_nr_top.sv

  # Testbench
  - target: test
    files:
      - tests/tb_fp2_nr_top.sv

//--- tests/tb_fp2_nr_top.sv
module tb_fp2_nr_top;

  // Element counts per test
  localparam int N_RAND = 200;
  localparam int N_BP = 120;
  localparam int N_GAP = 100;
  localparam int N_ELEMS = 1 + 4 + N_RAND + N_BP + N_GAP;
  // Cycle budget for the whole run
  localparam int CYC_LIMIT = 30 * N_ELEMS + 200;
  localparam int unsigned MOD = fp2_nr_pkg::P;

  logic             i_clk;
  logic             i_rst;
  logic             i_val;
  fp2_nr_pkg::fe_t  i_dat;
  logic             i_sop;
  logic             i_eop;
  fp2_nr_pkg::ctl_t i_ctl;
  logic             o_in_rdy;
  logic             o_val;
  fp2_nr_pkg::fe_t  o_dat;
  logic             o_sop;
  logic             o_eop;
  fp2_nr_pkg::ctl_t o_ctl;
  logic             i_out_rdy;

  // Expected output beats, oldest first
  int unsigned exp_dat[$];
  int unsigned exp_ctl[$];
  bit          exp_sop[$];

  int               cyc = 0;
  int               last_eop_cyc;
  int               c0_xfer_cyc;
  int               c1_xfer_cyc;
  // Output beat seen stalled on the previous edge
  bit               held = 0;
  fp2_nr_pkg::fe_t  held_dat;
  fp2_nr_pkg::ctl_t held_ctl;
  logic             held_sop;
  logic             held_eop;
  bit               stall_seen = 0;
  bit               recover_seen = 0;
  int unsigned      seed_val;

  fp2_nr_top i_dut (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_val     (i_val),
    .i_dat     (i_dat),
    .i_sop     (i_sop),
    .i_eop     (i_eop),
    .i_ctl     (i_ctl),
    .o_in_rdy  (o_in_rdy),
    .o_val     (o_val),
    .o_dat     (o_dat),
    .o_sop     (o_sop),
    .o_eop     (o_eop),
    .o_ctl     (o_ctl),
    .i_out_rdy (i_out_rdy)
  );

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input int unsigned exp,
                               input int unsigned act);
    assert (exp == act) else begin
      $display("mismatch t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // Reference rule, c0' = c0 - c1 mod P
  function automatic int unsigned diff_mod_p(input int unsigned a, input int unsigned b);
    return (a + MOD - b) % MOD;
  endfunction

  // Reference rule, c1' = c0 + c1 mod P
  function automatic int unsigned sum_mod_p(input int unsigned a, input int unsigned b);
    return (a + b) % MOD;
  endfunction

  // Edge counter and run limit
  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    assert (cyc < CYC_LIMIT) else stop_on_error($sformatf("timeout after %0d cycles", cyc));
  end

  // Output monitor, sampled on the rising edge
  always @(posedge i_clk) begin
    if (!i_rst) begin
      // A stalled beat must not move or change
      if (held) begin
        compare_value("o_val (held)", 1, o_val);
        compare_value("o_dat (held)", held_dat, o_dat);
        compare_value("o_ctl (held)", held_ctl, o_ctl);
        compare_value("o_sop (held)", held_sop, o_sop);
        compare_value("o_eop (held)", held_eop, o_eop);
      end
      if (o_val && i_out_rdy) begin
        assert (exp_dat.size() != 0) else stop_on_error("output beat with no element outstanding");
        compare_value("o_dat", exp_dat[0], o_dat);
        compare_value("o_ctl", exp_ctl[0], o_ctl);
        compare_value("o_sop", exp_sop[0], o_sop);
        compare_value("o_eop", !exp_sop[0], o_eop);
        if (o_sop) begin
          c0_xfer_cyc = cyc;
        end else begin
          c1_xfer_cyc = cyc;
        end
        void'(exp_dat.pop_front());
        void'(exp_ctl.pop_front());
        void'(exp_sop.pop_front());
      end
      held     = o_val && !i_out_rdy;
      held_dat = o_dat;
      held_ctl = o_ctl;
      held_sop = o_sop;
      held_eop = o_eop;
      // Input stall, then recovery
      if (i_val && !o_in_rdy) begin
        stall_seen = 1;
      end else if (stall_seen && i_val && o_in_rdy) begin
        recover_seen = 1;
      end
    end
  end

  // One input beat, held until taken
  task automatic drive_beat(input int unsigned dat, input bit sop, input bit eop,
                            input int unsigned ctl);
    @(negedge i_clk);
    i_val = 1'b1;
    i_dat = fp2_nr_pkg::fe_t'(dat);
    i_sop = sop;
    i_eop = eop;
    i_ctl = fp2_nr_pkg::ctl_t'(ctl);
    @(posedge i_clk);
    while (!o_in_rdy) @(posedge i_clk);
    if (eop) begin
      last_eop_cyc = cyc;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge i_clk);
      i_val = 1'b0;
      i_sop = 1'b0;
      i_eop = 1'b0;
      @(posedge i_clk);
    end
  endtask

  task automatic release_inputs();
    @(negedge i_clk);
    i_val = 1'b0;
    i_sop = 1'b0;
    i_eop = 1'b0;
  endtask

  // Queue both result beats, then send c0 and c1 with optional gaps
  task automatic push_element(input int unsigned c0, input int unsigned c1,
                              input int unsigned ctl, input int max_gap);
    exp_dat.push_back(diff_mod_p(c0, c1));
    exp_ctl.push_back(ctl);
    exp_sop.push_back(1'b1);
    exp_dat.push_back(sum_mod_p(c0, c1));
    exp_ctl.push_back(ctl);
    exp_sop.push_back(1'b0);
    drive_beat(c0, 1'b1, 1'b0, ctl);
    if (max_gap > 0) idle_cycles($urandom % (max_gap + 1));
    drive_beat(c1, 1'b0, 1'b1, ctl);
    if (max_gap > 0) idle_cycles($urandom % (max_gap + 1));
  endtask

  task automatic random_element(input int max_gap);
    int unsigned a;
    int unsigned b;
    int unsigned t;
    a = $urandom % MOD;
    b = $urandom % MOD;
    t = $urandom % 256;
    push_element(a, b, t, max_gap);
  endtask

  // Wait until every expected beat has left, then watch for extras
  task automatic drain_outputs();
    release_inputs();
    while (exp_dat.size() != 0) @(posedge i_clk);
    repeat (5) @(posedge i_clk);
  endtask

  task automatic reset_state_check();
    @(posedge i_clk);
    compare_value("o_val", 0, o_val);
    compare_value("o_in_rdy", 1, o_in_rdy);
  endtask

  // c0' loaded on eop edge + 2, so taken on + 3
  task automatic single_element();
    random_element(0);
    drain_outputs();
    compare_value("o_sop beat edge", last_eop_cyc + 3, c0_xfer_cyc);
    compare_value("o_eop beat edge", last_eop_cyc + 4, c1_xfer_cyc);
  endtask

  // Adder wrap and subtractor borrow
  task automatic edge_operands();
    push_element(0, 0, 8'h11, 0);
    push_element(MOD - 1, MOD - 1, 8'h22, 0);
    push_element(0, MOD - 1, 8'h33, 0);
    push_element(MOD - 1, 0, 8'h44, 0);
    drain_outputs();
  endtask

  task automatic back_to_back_stream();
    repeat (N_RAND) random_element(0);
    drain_outputs();
  endtask

  task automatic output_backpressure();
    bit sent_all;
    sent_all = 0;
    stall_seen = 0;
    recover_seen = 0;
    fork
      begin
        repeat (N_BP) random_element(0);
        drain_outputs();
        sent_all = 1;
      end
      begin
        // Ready held low first so the pipeline fills up
        @(negedge i_clk);
        i_out_rdy = 1'b0;
        repeat (40) @(negedge i_clk);
        while (!sent_all) begin
          @(negedge i_clk);
          i_out_rdy = ($urandom % 100) < 40;
        end
        i_out_rdy = 1'b1;
      end
    join
    assert (stall_seen && recover_seen)
      else stop_on_error("o_in_rdy did not stall and recover under output back-pressure");
  endtask

  task automatic gapped_input();
    repeat (N_GAP) random_element(3);
    drain_outputs();
  endtask

  initial begin
    seed_val  = $urandom(73);
    i_rst     = 1'b1;
    i_val     = 1'b0;
    i_dat     = '0;
    i_sop     = 1'b0;
    i_eop     = 1'b0;
    i_ctl     = '0;
    i_out_rdy = 1'b1;
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    reset_state_check();
    single_element();
    edge_operands();
    back_to_back_stream();
    output_backpressure();
    gapped_input();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- hw/fp2_nr_top.sv
module fp2_nr_top (
  input  logic             i_clk,
  input  logic             i_rst,
  // Element stream in
  input  logic             i_val,
  input  fp2_nr_pkg::fe_t  i_dat,
  input  logic             i_sop,
  input  logic             i_eop,
  input  fp2_nr_pkg::ctl_t i_ctl,
  output logic             o_in_rdy,
  // Result stream out
  output logic             o_val,
  output fp2_nr_pkg::fe_t  o_dat,
  output logic             o_sop,
  output logic             o_eop,
  output fp2_nr_pkg::ctl_t o_ctl,
  input  logic             i_out_rdy
);
  import fp2_nr_pkg::*;

  // Pair requests from the stream block
  logic add_req_val;
  fe2_t add_req_dat;
  ctl_t add_req_ctl;
  logic add_req_rdy;
  logic sub_req_val;
  fe2_t sub_req_dat;
  ctl_t sub_req_ctl;
  logic sub_req_rdy;

  // Results back to the stream block
  logic add_res_val;
  fe_t  add_res_dat;
  ctl_t add_res_ctl;
  logic add_res_rdy;
  logic sub_res_val;
  fe_t  sub_res_dat;
  ctl_t sub_res_ctl;
  logic sub_res_rdy;

  // Pairing and re-serialising
  fe2_mul_by_nonresidue_s u_nr (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_val     (i_val),
    .i_dat     (i_dat),
    .i_sop     (i_sop),
    .i_eop     (i_eop),
    .i_ctl     (i_ctl),
    .o_rdy     (o_in_rdy),
    .o_val     (o_val),
    .o_dat     (o_dat),
    .o_sop     (o_sop),
    .o_eop     (o_eop),
    .o_ctl     (o_ctl),
    .i_rdy     (i_out_rdy),
    .o_add_val (add_req_val),
    .o_add_dat (add_req_dat),
    .o_add_ctl (add_req_ctl),
    .i_add_rdy (add_req_rdy),
    .o_sub_val (sub_req_val),
    .o_sub_dat (sub_req_dat),
    .o_sub_ctl (sub_req_ctl),
    .i_sub_rdy (sub_req_rdy),
    .i_add_val (add_res_val),
    .i_add_dat (add_res_dat),
    .i_add_ctl (add_res_ctl),
    .o_add_rdy (add_res_rdy),
    .i_sub_val (sub_res_val),
    .i_sub_dat (sub_res_dat),
    .i_sub_ctl (sub_res_ctl),
    .o_sub_rdy (sub_res_rdy)
  );

  // c1' = c0 + c1
  fe_add_mod u_add (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (add_req_val),
    .i_dat (add_req_dat),
    .i_ctl (add_req_ctl),
    .o_rdy (add_req_rdy),
    .o_val (add_res_val),
    .o_dat (add_res_dat),
    .o_ctl (add_res_ctl),
    .i_rdy (add_res_rdy)
  );

  // c0' = c0 - c1
  fe_sub_mod u_sub (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (sub_req_val),
    .i_dat (sub_req_dat),
    .i_ctl (sub_req_ctl),
    .o_rdy (sub_req_rdy),
    .o_val (sub_res_val),
    .o_dat (sub_res_dat),
    .o_ctl (sub_res_ctl),
    .i_rdy (sub_res_rdy)
  );

endmodule

//--- hw/fe2_mul_by_nonresidue_s.sv
module fe2_mul_by_nonresidue_s (
  input  logic             i_clk,
  input  logic             i_rst,
  // Element stream in, c0 beat then c1 beat
  input  logic             i_val,
  input  fp2_nr_pkg::fe_t  i_dat,
  input  logic             i_sop,
  input  logic             i_eop,
  input  fp2_nr_pkg::ctl_t i_ctl,
  output logic             o_rdy,
  // Result stream out, c0' beat then c1' beat
  output logic             o_val,
  output fp2_nr_pkg::fe_t  o_dat,
  output logic             o_sop,
  output logic             o_eop,
  output fp2_nr_pkg::ctl_t o_ctl,
  input  logic             i_rdy,
  // Pair to the adder
  output logic             o_add_val,
  output fp2_nr_pkg::fe2_t o_add_dat,
  output fp2_nr_pkg::ctl_t o_add_ctl,
  input  logic             i_add_rdy,
  // Pair to the subtractor
  output logic             o_sub_val,
  output fp2_nr_pkg::fe2_t o_sub_dat,
  output fp2_nr_pkg::ctl_t o_sub_ctl,
  input  logic             i_sub_rdy,
  // Sum back from the adder
  input  logic             i_add_val,
  input  fp2_nr_pkg::fe_t  i_add_dat,
  input  fp2_nr_pkg::ctl_t i_add_ctl,
  output logic             o_add_rdy,
  // Difference back from the subtractor
  input  logic             i_sub_val,
  input  fp2_nr_pkg::fe_t  i_sub_dat,
  input  fp2_nr_pkg::ctl_t i_sub_ctl,
  output logic             o_sub_rdy
);
  import fp2_nr_pkg::*;

  // Which result goes out next
  typedef enum logic {
    PH_C0,
    PH_C1
  } phase_t;

  phase_t phase;
  fe2_t   pair_dat;
  ctl_t   pair_ctl;
  logic   add_pend;
  logic   sub_pend;
  logic   half_pend;
  logic   in_take;
  logic   out_free;

  // Same pair and tag offered to both units
  assign o_add_val = add_pend;
  assign o_add_dat = pair_dat;
  assign o_add_ctl = pair_ctl;
  assign o_sub_val = sub_pend;
  assign o_sub_dat = pair_dat;
  assign o_sub_ctl = pair_ctl;

  always_comb begin
    // Take a beat once each unit has the pair or takes it now
    o_rdy   = (!add_pend || i_add_rdy) && (!sub_pend || i_sub_rdy);
    in_take = i_val && o_rdy;
    // Output register empty, or its beat leaves this edge
    out_free = !o_val || i_rdy;
    // Results drain in stream order, difference first
    o_sub_rdy = (phase == PH_C0) && out_free;
    o_add_rdy = (phase == PH_C1) && out_free;
  end

  // Pair valids, one per unit, cleared as each unit takes the pair
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      add_pend  <= 1'b0;
      sub_pend  <= 1'b0;
      half_pend <= 1'b0;
    end else begin
      if (i_add_rdy) begin
        add_pend <= 1'b0;
      end
      if (i_sub_rdy) begin
        sub_pend <= 1'b0;
      end
      if (in_take) begin
        // c0 seen, waiting on c1
        half_pend <= !i_eop;
        // c1 completes the pair
        if (i_eop) begin
          add_pend <= 1'b1;
          sub_pend <= 1'b1;
        end
      end
    end
  end

  // Pair payload
  always_ff @(posedge i_clk) begin
    if (in_take) begin
      if (i_sop) begin
        pair_dat[FE_W-1:0] <= i_dat;
      end else begin
        pair_dat[2*FE_W-1:FE_W] <= i_dat;
      end
      // Tag of the last beat wins
      pair_ctl <= i_ctl;
    end
  end

  // Output valid and phase
  // Phase moves only when a result is actually taken
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      phase <= PH_C0;
    end else if (out_free) begin
      case (phase)
        PH_C0: begin
          o_val <= i_sub_val;
          if (i_sub_val) begin
            phase <= PH_C1;
          end
        end
        PH_C1: begin
          o_val <= i_add_val;
          if (i_add_val) begin
            phase <= PH_C0;
          end
        end
      endcase
    end
  end

  // Output beat payload
  always_ff @(posedge i_clk) begin
    if (out_free) begin
      case (phase)
        PH_C0: begin
          // c0' = c0 - c1
          if (i_sub_val) begin
            o_dat <= i_sub_dat;
            o_ctl <= i_sub_ctl;
            o_sop <= 1'b1;
            o_eop <= 1'b0;
          end
        end
        PH_C1: begin
          // c1' = c0 + c1
          if (i_add_val) begin
            o_dat <= i_add_dat;
            o_ctl <= i_add_ctl;
            o_sop <= 1'b0;
            o_eop <= 1'b1;
          end
        end
      endcase
    end
  end

  // The adder drains after the subtractor, so it never takes a pair
  // that the subtractor still owes, and the two valids only ever split
  // with the adder one behind
  a_pair_valids: assert property (
    @(posedge i_clk) disable iff (i_rst)
    sub_pend |-> add_pend
  );

  // Framing, a new c0 beat only after the previous c1 beat
  a_no_sop_in_half: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (i_val && o_rdy && i_sop) |-> !half_pend
  );

endmodule

//--- hw/fe_sub_mod.sv
module fe_sub_mod (
  input  logic             i_clk,
  input  logic             i_rst,
  // Operand pair in
  input  logic             i_val,
  input  fp2_nr_pkg::fe2_t i_dat,
  input  fp2_nr_pkg::ctl_t i_ctl,
  output logic             o_rdy,
  // Registered difference out
  output logic             o_val,
  output fp2_nr_pkg::fe_t  o_dat,
  output fp2_nr_pkg::ctl_t o_ctl,
  input  logic             i_rdy
);
  import fp2_nr_pkg::*;

  fe_t           op_a;
  fe_t           op_b;
  logic [FE_W:0] diff_raw;
  logic          borrow;
  fe_t           diff_mod;

  // Split the pair, c0 low and c1 high
  always_comb begin
    op_a = i_dat[FE_W-1:0];
    op_b = i_dat[2*FE_W-1:FE_W];
  end

  // c0 - c1 with one extra bit to catch the borrow
  always_comb begin
    diff_raw = {1'b0, op_a} - {1'b0, op_b};
    borrow   = diff_raw[FE_W];
    // Negative result, fold back by adding P
    // Low bits wrap mod 2^FE_W so the sum lands in range
    diff_mod = borrow ? diff_raw[FE_W-1:0] + P : diff_raw[FE_W-1:0];
  end

  // Output register free, or drained on this edge
  assign o_rdy = !o_val || i_rdy;

  // Output valid
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  // Result and tag, loaded with each accepted pair
  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_dat <= diff_mod;
      o_ctl <= i_ctl;
    end
  end

  // Reduced operands from the stream block must give a reduced difference
  a_diff_below_p: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_dat < P)
  );

endmodule

//--- hw/fe_add_mod.sv
module fe_add_mod (
  input  logic             i_clk,
  input  logic             i_rst,
  // Operand pair in
  input  logic             i_val,
  input  fp2_nr_pkg::fe2_t i_dat,
  input  fp2_nr_pkg::ctl_t i_ctl,
  output logic             o_rdy,
  // Registered sum out
  output logic             o_val,
  output fp2_nr_pkg::fe_t  o_dat,
  output fp2_nr_pkg::ctl_t o_ctl,
  input  logic             i_rdy
);
  import fp2_nr_pkg::*;

  fe_t           op_a;
  fe_t           op_b;
  logic [FE_W:0] sum_raw;
  logic [FE_W:0] sum_red;
  fe_t           sum_mod;

  // Split the pair, c0 low and c1 high
  always_comb begin
    op_a = i_dat[FE_W-1:0];
    op_b = i_dat[2*FE_W-1:FE_W];
  end

  // Full sum with carry bit, then trial subtract of P
  always_comb begin
    sum_raw = {1'b0, op_a} + {1'b0, op_b};
    sum_red = sum_raw - {1'b0, P};
    // Top bit set means the sum was below P, keep it as is
    sum_mod = sum_red[FE_W] ? sum_raw[FE_W-1:0] : sum_red[FE_W-1:0];
  end

  // Output register free, or drained on this edge
  assign o_rdy = !o_val || i_rdy;

  // Output valid
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  // Result and tag, loaded with each accepted pair
  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_dat <= sum_mod;
      o_ctl <= i_ctl;
    end
  end

  // Reduced operands from the stream block must give a reduced sum
  a_sum_below_p: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_dat < P)
  );

endmodule

//--- hw/fp2_nr_pkg.sv
package fp2_nr_pkg;

  // Width of one Fp element
  localparam int FE_W = 16;

  // Width of the control tag sent with each element
  localparam int CTL_W = 8;

  // One Fp element, always kept below P
  typedef logic [FE_W-1:0] fe_t;

  // Pair of Fp elements
  // Low half c0, high half c1
  typedef logic [2*FE_W-1:0] fe2_t;

  // Control tag, passed through untouched
  typedef logic [CTL_W-1:0] ctl_t;

  // Field modulus, largest 16-bit prime
  // A wider curve prime only needs FE_W and P changed
  localparam fe_t P = fe_t'(65521);

endpackage
